//--- Makefile
VERILATOR ?= verilator
TB_TOP    ?= tb_dsi_tx
RTL_TOP   ?= dsi_tx_top
FILELIST  ?= dsi_tx.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -q "=== PASS ===" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall \
		dsi_tx_pkg.sv dsi_tx_pixel_buffer.sv dsi_tx_packet_assembler.sv \
		dsi_tx_lane_controller.sv dsi_tx_top.sv --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dsi_tx.f
dsi_tx_pkg.sv
dsi_tx_pixel_buffer.sv
dsi_tx_packet_assembler.sv
dsi_tx_lane_controller.sv
dsi_tx_top.sv
tb_dsi_tx.sv

//--- dsi_tx_lane_controller.sv
module dsi_tx_lane_controller (
    input  logic                    clk_phy,
    input  logic                    arst_n,
    input  dsi_tx_pkg::lane_count_t lane_count,

    // packet word stream
    input  logic                    burst_req,
    input  dsi_tx_pkg::word_t       word_data,
    input  dsi_tx_pkg::byte_count_t word_bytes,
    input  logic                    word_last,
    input  logic                    word_valid,
    output logic                    word_ready,

    // data lanes
    output dsi_tx_pkg::lane_mask_t  lp_p,
    output dsi_tx_pkg::lane_mask_t  lp_n,
    output dsi_tx_pkg::lane_mask_t  hs_en,
    output dsi_tx_pkg::lane_mask_t  hs_valid,
    output dsi_tx_pkg::lane_bytes_t hs_data
);

    dsi_tx_pkg::lane_state_t state;
    logic [7:0]              cnt;        // shared phase counter
    logic [7:0]              cnt_limit;
    logic                    cnt_done;
    logic                    timed;
    logic                    in_hs;
    logic                    in_data;
    dsi_tx_pkg::lane_mask_t  act_mask;   // lanes 0 to lane_count-1
    logic [2:0]              lanes_n;
    dsi_tx_pkg::byte_count_t idx;        // first byte of the current group
    logic [3:0]              grp_end;
    dsi_tx_pkg::lane_mask_t  lane_used;
    logic [3:0]              lane_pos [4];
    dsi_tx_pkg::byte_t       data_byte [4];
    dsi_tx_pkg::byte_t       trail_byte [4];
    dsi_tx_pkg::byte_t       last_byte [4];

    // 3 is not supported and falls back to four lanes
    always_comb begin
        case (lane_count)
            3'd1: begin
                act_mask = 4'b0001;
                lanes_n  = 3'd1;
            end
            3'd2: begin
                act_mask = 4'b0011;
                lanes_n  = 3'd2;
            end
            default: begin
                act_mask = 4'b1111;
                lanes_n  = 3'd4;
            end
        endcase
    end

    always_comb begin
        case (state)
            dsi_tx_pkg::LP01:     cnt_limit = dsi_tx_pkg::TLPX_CYCLES;
            dsi_tx_pkg::LP00:     cnt_limit = dsi_tx_pkg::HS_PREPARE_CYCLES;
            dsi_tx_pkg::HS_ZERO:  cnt_limit = dsi_tx_pkg::HS_ZERO_CYCLES;
            dsi_tx_pkg::HS_TRAIL: cnt_limit = dsi_tx_pkg::HS_TRAIL_CYCLES;
            default:              cnt_limit = dsi_tx_pkg::HS_EXIT_CYCLES;
        endcase
    end

    assign cnt_done = cnt == cnt_limit - 8'd1;
    assign timed    = state inside {dsi_tx_pkg::LP01, dsi_tx_pkg::LP00, dsi_tx_pkg::HS_ZERO,
                                    dsi_tx_pkg::HS_TRAIL, dsi_tx_pkg::LP11_EXIT};
    assign in_hs    = state inside {dsi_tx_pkg::HS_ZERO, dsi_tx_pkg::HS_SYNC,
                                    dsi_tx_pkg::HS_DATA, dsi_tx_pkg::HS_TRAIL};
    assign in_data  = state == dsi_tx_pkg::HS_DATA;

    // word is done when this group reaches its last byte
    assign grp_end    = {1'b0, idx} + {1'b0, lanes_n};
    assign word_ready = in_data && (grp_end >= {1'b0, word_bytes});

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            lane_pos[k]   = {1'b0, idx} + k[3:0];
            lane_used[k]  = in_data && word_valid && act_mask[k] &&
                            (lane_pos[k] < {1'b0, word_bytes});
            data_byte[k]  = word_data[lane_pos[k][1:0]*8 +: 8];
            trail_byte[k] = {8{~last_byte[k][7]}};
        end
    end

    always_ff @(posedge clk_phy or negedge arst_n) begin
        if (!arst_n) begin
            state <= dsi_tx_pkg::LP11_IDLE;
            cnt   <= '0;
            idx   <= '0;
        end else begin
            if (timed && !cnt_done) begin
                cnt <= cnt + 8'd1;
            end else begin
                cnt <= '0;  // fresh count on every phase change
            end
            if (in_data && word_valid) begin
                idx <= word_ready ? '0 : grp_end[2:0];
            end else if (!in_data) begin
                idx <= '0;
            end
            case (state)
                dsi_tx_pkg::LP11_IDLE: if (burst_req) state <= dsi_tx_pkg::LP01;
                dsi_tx_pkg::LP01:      if (cnt_done) state <= dsi_tx_pkg::LP00;
                dsi_tx_pkg::LP00:      if (cnt_done) state <= dsi_tx_pkg::HS_ZERO;
                dsi_tx_pkg::HS_ZERO:   if (cnt_done) state <= dsi_tx_pkg::HS_SYNC;
                dsi_tx_pkg::HS_SYNC:   state <= dsi_tx_pkg::HS_DATA;
                dsi_tx_pkg::HS_DATA: begin
                    if (word_valid && word_ready && word_last) begin
                        state <= dsi_tx_pkg::HS_TRAIL;
                    end
                end
                dsi_tx_pkg::HS_TRAIL:  if (cnt_done) state <= dsi_tx_pkg::LP11_EXIT;
                default:               if (cnt_done) state <= dsi_tx_pkg::LP11_IDLE;
            endcase
        end
    end

    // last byte sent per lane, sets the trail polarity
    always_ff @(posedge clk_phy) begin
        for (int k = 0; k < 4; k++) begin
            if (state == dsi_tx_pkg::HS_SYNC) begin
                last_byte[k] <= dsi_tx_pkg::SYNC_BYTE;
            end else if (lane_used[k]) begin
                last_byte[k] <= data_byte[k];
            end
        end
    end

    // LP levels: 01 request, 00 prepare and during HS, 11 otherwise
    assign lp_p     = (timed && state != dsi_tx_pkg::LP11_EXIT) || in_hs ? ~act_mask : '1;
    assign lp_n     = (state == dsi_tx_pkg::LP00) || in_hs ? ~act_mask : '1;
    assign hs_en    = in_hs ? act_mask : '0;
    assign hs_valid = lane_used;

    always_comb begin
        dsi_tx_pkg::byte_t lane_byte;
        hs_data = '0;
        for (int k = 0; k < 4; k++) begin
            case (state)
                dsi_tx_pkg::HS_SYNC:  lane_byte = dsi_tx_pkg::SYNC_BYTE;
                dsi_tx_pkg::HS_DATA:  lane_byte = lane_used[k] ? data_byte[k] : trail_byte[k];
                dsi_tx_pkg::HS_TRAIL: lane_byte = trail_byte[k];
                default:              lane_byte = '0;  // HS zero and LP states
            endcase
            hs_data[k*8 +: 8] = act_mask[k] ? lane_byte : 8'h00;
        end
    end

endmodule

//--- dsi_tx_packet_assembler.sv
module dsi_tx_packet_assembler (
    input  logic                    clk_phy,
    input  logic                    arst_n,

    // pixel buffer side
    input  dsi_tx_pkg::word_t       fifo_data,
    input  logic                    line_ready,
    output logic                    fifo_read,

    // lane controller side
    output logic                    burst_req,
    output dsi_tx_pkg::word_t       word_data,
    output dsi_tx_pkg::byte_count_t word_bytes,
    output logic                    word_last,
    output logic                    word_valid,
    input  logic                    word_ready
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_PAYLOAD,
        ST_CRC
    } asm_state_t;

    asm_state_t                   state;
    logic [dsi_tx_pkg::FIFO_AW:0] pay_cnt;  // payload words accepted so far
    logic [15:0]                  crc;
    logic                         accept;
    dsi_tx_pkg::word_t            header;

    // Hamming-style ECC over the 24 header bits, one parity mask per ECC bit
    function automatic logic [5:0] ecc6(input logic [23:0] d);
        logic [5:0] p;
        p[0] = ^(d & 24'hF12CB7);
        p[1] = ^(d & 24'hF2555B);
        p[2] = ^(d & 24'h749A6D);
        p[3] = ^(d & 24'hB8E38E);
        p[4] = ^(d & 24'hDF03F0);
        p[5] = ^(d & 24'hEFFC00);
        return p;
    endfunction

    // CRC-16 x16+x12+x5+1, reflected form, bytes and bits LSB first
    function automatic logic [15:0] crc16_word(input logic [15:0] crc_in,
                                               input dsi_tx_pkg::word_t data);
        logic [15:0] c;
        c = crc_in;
        for (int i = 0; i < 32; i++) begin
            if (c[0] ^ data[i]) begin
                c = (c >> 1) ^ 16'h8408;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // header bytes: data ID, WC low, WC high, ECC
    assign header = {2'b00,
                     ecc6({dsi_tx_pkg::LINE_BYTES, dsi_tx_pkg::DATA_ID}),
                     dsi_tx_pkg::LINE_BYTES[15:8],
                     dsi_tx_pkg::LINE_BYTES[7:0],
                     dsi_tx_pkg::DATA_ID};

    assign accept = word_valid && word_ready;

    always_ff @(posedge clk_phy or negedge arst_n) begin
        if (!arst_n) begin
            state   <= ST_IDLE;
            pay_cnt <= '0;
            crc     <= 16'hFFFF;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (line_ready) begin  // commit to the buffered line
                        state   <= ST_HEADER;
                        pay_cnt <= '0;
                        crc     <= 16'hFFFF;
                    end
                end
                ST_HEADER: begin
                    if (accept) begin
                        state <= ST_PAYLOAD;
                    end
                end
                ST_PAYLOAD: begin
                    if (accept) begin
                        crc     <= crc16_word(crc, fifo_data);
                        pay_cnt <= pay_cnt + 1'b1;
                        if (pay_cnt == dsi_tx_pkg::LINE_WORDS - 1'b1) begin
                            state <= ST_CRC;
                        end
                    end
                end
                default: begin
                    if (accept) begin
                        state <= ST_IDLE;  // footer gone, burst done
                    end
                end
            endcase
        end
    end

    assign burst_req  = state != ST_IDLE;
    assign word_valid = state != ST_IDLE;  // no gaps once the line is committed
    assign word_last  = state == ST_CRC;
    assign fifo_read  = (state == ST_PAYLOAD) && accept;  // pop on handoff

    always_comb begin
        case (state)
            ST_HEADER: begin
                word_data  = header;
                word_bytes = dsi_tx_pkg::byte_count_t'(4);
            end
            ST_CRC: begin
                word_data  = {16'h0000, crc};  // low CRC byte goes first
                word_bytes = dsi_tx_pkg::byte_count_t'(2);
            end
            default: begin
                word_data  = fifo_data;
                word_bytes = dsi_tx_pkg::byte_count_t'(4);
            end
        endcase
    end

endmodule

//--- dsi_tx_pixel_buffer.sv
module dsi_tx_pixel_buffer (
    input  logic                clk_phy,
    input  logic                arst_n,

    // pixel stream sink
    input  dsi_tx_pkg::word_t   pix_data,
    input  logic                pix_valid,
    output logic                pix_ready,

    // show-ahead read side
    output dsi_tx_pkg::word_t   fifo_data,
    output logic                line_ready,
    input  logic                fifo_read
);

    dsi_tx_pkg::word_t              mem [dsi_tx_pkg::FIFO_DEPTH];
    logic [dsi_tx_pkg::FIFO_AW-1:0] wr_ptr;
    logic [dsi_tx_pkg::FIFO_AW-1:0] rd_ptr;
    logic [dsi_tx_pkg::FIFO_AW:0]   count;   // occupancy, 0 to FIFO_DEPTH
    logic                           push;
    logic                           pop;

    assign pix_ready = count != dsi_tx_pkg::FIFO_DEPTH;
    assign push      = pix_valid && pix_ready;
    assign pop       = fifo_read && (count != '0);  // no pop from an empty FIFO

    // storage, written on every accepted word
    always_ff @(posedge clk_phy) begin
        if (push) begin
            mem[wr_ptr] <= pix_data;
        end
    end

    always_ff @(posedge clk_phy or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at FIFO_DEPTH
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;  // both or neither
                end
            endcase
        end
    end

    assign fifo_data = mem[rd_ptr];  // head word, valid while count != 0

    // a whole line can be drained without waiting on the source
    assign line_ready = count >= dsi_tx_pkg::LINE_WORDS;

endmodule

//--- dsi_tx_pkg.sv
package dsi_tx_pkg;

    typedef logic [31:0] word_t;        // pixel or packet word, byte 0 in the low bits
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] lane_bytes_t;  // lane i in bits 8i upward
    typedef logic [3:0]  lane_mask_t;   // one bit per data lane
    typedef logic [2:0]  lane_count_t;  // 1, 2 or 4
    typedef logic [2:0]  byte_count_t;  // valid bytes in a packet word
    typedef logic [15:0] word_count_t;  // DSI payload byte count

    // line geometry and buffering
    localparam word_count_t LINE_BYTES = 16'd16;
    localparam int          FIFO_AW    = 4;
    localparam logic [FIFO_AW:0] FIFO_DEPTH = 5'd16;  // must equal 2**FIFO_AW
    localparam logic [FIFO_AW:0] LINE_WORDS = (FIFO_AW + 1)'(LINE_BYTES / 4);

    // packet constants
    localparam byte_t DATA_ID   = 8'h3E;  // 24-bit RGB888 long packet, vc 0
    localparam byte_t SYNC_BYTE = 8'hB8;  // HS leader

    // D-PHY timing in clk_phy cycles
    localparam logic [7:0] TLPX_CYCLES       = 8'd4;
    localparam logic [7:0] HS_PREPARE_CYCLES = 8'd4;
    localparam logic [7:0] HS_ZERO_CYCLES    = 8'd6;
    localparam logic [7:0] HS_TRAIL_CYCLES   = 8'd4;
    localparam logic [7:0] HS_EXIT_CYCLES    = 8'd6;

    typedef enum logic [2:0] {
        LP11_IDLE,  // stop state, waiting for a burst
        LP01,       // HS request
        LP00,       // HS prepare
        HS_ZERO,
        HS_SYNC,
        HS_DATA,
        HS_TRAIL,
        LP11_EXIT
    } lane_state_t;

endpackage

//--- dsi_tx_top.sv
module dsi_tx_top (
    input  logic                    clk_phy,
    input  logic                    arst_n,

    // pixel stream input
    input  dsi_tx_pkg::word_t       pix_data,
    input  logic                    pix_valid,
    output logic                    pix_ready,

    input  dsi_tx_pkg::lane_count_t lane_count,  // change only between bursts

    // data lanes
    output dsi_tx_pkg::lane_mask_t  lp_p,
    output dsi_tx_pkg::lane_mask_t  lp_n,
    output dsi_tx_pkg::lane_mask_t  hs_en,
    output dsi_tx_pkg::lane_mask_t  hs_valid,
    output dsi_tx_pkg::lane_bytes_t hs_data
);

    dsi_tx_pkg::word_t       fifo_data;
    logic                    line_ready;
    logic                    fifo_read;
    logic                    burst_req;
    dsi_tx_pkg::word_t       word_data;
    dsi_tx_pkg::byte_count_t word_bytes;
    logic                    word_last;
    logic                    word_valid;
    logic                    word_ready;

    dsi_tx_pixel_buffer dsi_tx_pixel_buffer_0 (
        .clk_phy    (clk_phy   ),
        .arst_n     (arst_n    ),
        .pix_data   (pix_data  ),
        .pix_valid  (pix_valid ),
        .pix_ready  (pix_ready ),
        .fifo_data  (fifo_data ),
        .line_ready (line_ready),
        .fifo_read  (fifo_read )
    );

    dsi_tx_packet_assembler dsi_tx_packet_assembler_0 (
        .clk_phy    (clk_phy   ),
        .arst_n     (arst_n    ),
        .fifo_data  (fifo_data ),
        .line_ready (line_ready),
        .fifo_read  (fifo_read ),
        .burst_req  (burst_req ),
        .word_data  (word_data ),
        .word_bytes (word_bytes),
        .word_last  (word_last ),
        .word_valid (word_valid),
        .word_ready (word_ready)
    );

    dsi_tx_lane_controller dsi_tx_lane_controller_0 (
        .clk_phy    (clk_phy   ),
        .arst_n     (arst_n    ),
        .lane_count (lane_count),
        .burst_req  (burst_req ),
        .word_data  (word_data ),
        .word_bytes (word_bytes),
        .word_last  (word_last ),
        .word_valid (word_valid),
        .word_ready (word_ready),
        .lp_p       (lp_p      ),
        .lp_n       (lp_n      ),
        .hs_en      (hs_en     ),
        .hs_valid   (hs_valid  ),
        .hs_data    (hs_data   )
    );

endmodule

//--- tb_dsi_tx.sv
module tb_dsi_tx;

    logic                    clk_phy;
    logic                    arst_n;
    dsi_tx_pkg::word_t       pix_data;
    logic                    pix_valid;
    logic                    pix_ready;
    dsi_tx_pkg::lane_count_t lane_count;
    dsi_tx_pkg::lane_mask_t  lp_p;
    dsi_tx_pkg::lane_mask_t  lp_n;
    dsi_tx_pkg::lane_mask_t  hs_en;
    dsi_tx_pkg::lane_mask_t  hs_valid;
    dsi_tx_pkg::lane_bytes_t hs_data;

    int                errors;
    logic [31:0]       seed;
    dsi_tx_pkg::word_t exp_words [$];  // words sent, not yet checked
    logic              saw_full;

    // per-burst record filled by the monitor
    int                      nb;
    int                      lp11_run;
    logic                    in_burst;
    logic                    seen_sync;
    logic                    leak;
    int                      lp01_len [8];
    int                      lp00_len [8];
    int                      zero_len [8];
    int                      trail_len [8];
    int                      gap_before [8];
    int                      nbytes [8];
    logic                    zero_ok [8];
    logic                    sync_ok [8];
    logic                    trail_ok [8];
    dsi_tx_pkg::byte_t       rx_bytes [8][32];
    dsi_tx_pkg::lane_bytes_t trail_rx [8];  // lane bytes of the first trail cycle

    dsi_tx_top i_dut (
        .clk_phy    (clk_phy   ),
        .arst_n     (arst_n    ),
        .pix_data   (pix_data  ),
        .pix_valid  (pix_valid ),
        .pix_ready  (pix_ready ),
        .lane_count (lane_count),
        .lp_p       (lp_p      ),
        .lp_n       (lp_n      ),
        .hs_en      (hs_en     ),
        .hs_valid   (hs_valid  ),
        .hs_data    (hs_data   )
    );

    initial begin
        clk_phy = 1'b0;
        forever #4 clk_phy = ~clk_phy;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    // DSI header ECC, one parity equation per bit
    function automatic logic [5:0] header_ecc(input logic [23:0] d);
        logic [5:0] p;
        p[0] = d[0]^d[1]^d[2]^d[4]^d[5]^d[7]^d[10]^d[11]^d[13]^d[16]^d[20]^d[21]^d[22]^d[23];
        p[1] = d[0]^d[1]^d[3]^d[4]^d[6]^d[8]^d[10]^d[12]^d[14]^d[17]^d[20]^d[21]^d[22]^d[23];
        p[2] = d[0]^d[2]^d[3]^d[5]^d[6]^d[9]^d[11]^d[12]^d[15]^d[18]^d[20]^d[21]^d[22];
        p[3] = d[1]^d[2]^d[3]^d[7]^d[8]^d[9]^d[13]^d[14]^d[15]^d[19]^d[20]^d[21]^d[23];
        p[4] = ^d[9:4] ^ ^d[20:16] ^ d[22] ^ d[23];
        p[5] = ^d[19:10] ^ d[21] ^ d[22] ^ d[23];
        return p;
    endfunction

    // one byte into the CRC-16 LFSR, bits LSB first
    function automatic logic [15:0] crc_byte(input logic [15:0] c, input logic [7:0] b);
        logic [15:0] r;
        logic        fb;
        r = c;
        for (int i = 0; i < 8; i++) begin
            fb = r[0] ^ b[i];
            r  = {fb, r[15:1]};
            r[10] = r[10] ^ fb;  // x5 tap
            r[3]  = r[3] ^ fb;   // x12 tap
        end
        return r;
    endfunction

    // burst monitor, samples at the rising edge
    always @(posedge clk_phy) begin
        if (arst_n) begin
            for (int k = 1; k < 4; k++) begin
                if (k >= lane_count && (hs_en[k] || hs_valid[k] || !lp_p[k] || !lp_n[k])) begin
                    leak = 1'b1;
                end
            end
            if (!hs_en[0] && !lp_p[0]) begin
                if (!in_burst) begin
                    in_burst = 1'b1;
                    seen_sync = 1'b0;
                    lp01_len[nb] = 0;
                    lp00_len[nb] = 0;
                    zero_len[nb] = 0;
                    trail_len[nb] = 0;
                    nbytes[nb] = 0;
                    zero_ok[nb] = 1'b1;
                    sync_ok[nb] = 1'b0;
                    trail_ok[nb] = 1'b1;
                    gap_before[nb] = lp11_run;
                end
                if (lp_n[0]) lp01_len[nb]++;
                else lp00_len[nb]++;
            end else if (hs_en[0] && in_burst) begin
                if (!seen_sync) begin
                    if (hs_data[7:0] == dsi_tx_pkg::SYNC_BYTE) begin
                        seen_sync = 1'b1;
                        sync_ok[nb] = 1'b1;
                        for (int k = 0; k < lane_count; k++) begin
                            if (hs_data[k*8 +: 8] != dsi_tx_pkg::SYNC_BYTE) sync_ok[nb] = 1'b0;
                        end
                    end else begin
                        zero_len[nb]++;
                        if (hs_data != '0) zero_ok[nb] = 1'b0;
                    end
                end else if (hs_valid != '0) begin
                    if (trail_len[nb] != 0) trail_ok[nb] = 1'b0;  // data after trail
                    for (int k = 0; k < 4; k++) begin
                        if (hs_valid[k]) begin
                            rx_bytes[nb][nbytes[nb] % 32] = hs_data[k*8 +: 8];
                            nbytes[nb]++;
                        end
                    end
                end else begin
                    if (trail_len[nb] == 0) begin
                        trail_rx[nb] = hs_data;
                    end else if (hs_data != trail_rx[nb]) begin
                        trail_ok[nb] = 1'b0;  // trail byte changed
                    end
                    trail_len[nb]++;
                end
            end
            if (!hs_en[0] && lp_p[0] && lp_n[0]) begin
                lp11_run++;
                if (in_burst) begin
                    in_burst = 1'b0;
                    nb = (nb < 7) ? nb + 1 : nb;
                end
            end else begin
                lp11_run = 0;
            end
        end
    end

    task automatic check_value(input logic ok, input string msg);
        assert (ok) else begin
            errors++;
            $display("error @%0t: %s", $time, msg);
        end
    endtask

    // drive n LCG words with valid/ready on falling edges
    task automatic send_words(input int n);
        int   i;
        int   t;
        logic taken;
        i = 0;
        t = 0;
        @(negedge clk_phy);
        pix_data  = lcg_next();
        pix_valid = 1'b1;
        exp_words.push_back(pix_data);
        while (i < n) begin
            taken = pix_ready;
            if (!pix_ready) saw_full = 1'b1;
            @(negedge clk_phy);
            if (taken) begin
                i++;
                t = 0;
                if (i < n) begin
                    pix_data = lcg_next();
                    exp_words.push_back(pix_data);
                end
            end else begin
                t++;
                if (t > 2000) begin
                    $display("pixel input stalled: pix_ready stayed low too long");
                    $display("errors: %0d", errors + 1);
                    $display("=== FAIL ===");
                    $finish;
                end
            end
        end
        pix_valid = 1'b0;
    endtask

    // wait for n bursts and a settled stop state
    task automatic wait_bursts(input int n);
        int t;
        t = 0;
        while (nb < n || lp11_run <= dsi_tx_pkg::HS_EXIT_CYCLES) begin
            @(negedge clk_phy);
            t++;
            if (t > 5000) begin
                $display("timed out waiting for %0d bursts, saw %0d", n, nb);
                $display("errors: %0d", errors + 1);
                $display("=== FAIL ===");
                $finish;
            end
        end
    endtask

    task automatic clear_monitor();
        nb   = 0;
        leak = 1'b0;
    endtask

    // compares burst b against the packet built from the next line of sent words
    task automatic check_burst(input int b);
        dsi_tx_pkg::byte_t exp [$];
        dsi_tx_pkg::word_t w;
        logic [15:0]       crc;
        dsi_tx_pkg::byte_t lane_last [4];  // last packet byte per lane
        int                lanes;
        crc = 16'hFFFF;
        exp.push_back(dsi_tx_pkg::DATA_ID);
        exp.push_back(8'd16);
        exp.push_back(8'd0);
        exp.push_back({2'b00, header_ecc({16'd16, dsi_tx_pkg::DATA_ID})});
        for (int i = 0; i < 4; i++) begin
            w = exp_words.pop_front();
            for (int j = 0; j < 4; j++) begin
                exp.push_back(w[j*8 +: 8]);
                crc = crc_byte(crc, w[j*8 +: 8]);
            end
        end
        exp.push_back(crc[7:0]);
        exp.push_back(crc[15:8]);
        lanes = int'(lane_count);
        for (int k = 0; k < 4; k++) begin
            lane_last[k] = dsi_tx_pkg::SYNC_BYTE;
        end
        for (int i = 0; i < exp.size(); i++) begin
            lane_last[i % lanes] = exp[i];  // packet bytes go round robin
        end
        check_value(lp01_len[b] == dsi_tx_pkg::TLPX_CYCLES, $sformatf("burst %0d lp01", b));
        check_value(lp00_len[b] == dsi_tx_pkg::HS_PREPARE_CYCLES, $sformatf("burst %0d lp00", b));
        check_value(zero_len[b] == dsi_tx_pkg::HS_ZERO_CYCLES && zero_ok[b],
                    $sformatf("burst %0d hs zero", b));
        check_value(sync_ok[b], $sformatf("burst %0d sync byte", b));
        check_value(nbytes[b] == exp.size(), $sformatf("burst %0d got %0d bytes", b, nbytes[b]));
        for (int i = 0; i < exp.size() && i < nbytes[b]; i++) begin
            check_value(rx_bytes[b][i] == exp[i], $sformatf("burst %0d byte %0d: %h, want %h",
                        b, i, rx_bytes[b][i], exp[i]));
        end
        check_value(trail_len[b] == dsi_tx_pkg::HS_TRAIL_CYCLES && trail_ok[b],
                    $sformatf("burst %0d trail", b));
        for (int k = 0; k < lanes; k++) begin
            check_value(trail_rx[b][k*8 +: 8] == {8{~lane_last[k][7]}},
                        $sformatf("burst %0d lane %0d trail byte %h",
                        b, k, trail_rx[b][k*8 +: 8]));
        end
    endtask

    task automatic one_line_test(input int lanes);
        @(negedge clk_phy);
        lane_count = 3'(lanes);
        clear_monitor();
        send_words(4);
        wait_bursts(1);
        check_burst(0);
        if (lanes < 4) begin
            check_value(!leak, $sformatf("unused lane active with %0d lanes", lanes));
        end
    endtask

    task automatic backpressure_test();
        @(negedge clk_phy);
        lane_count = 3'd1;
        clear_monitor();
        saw_full = 1'b0;
        send_words(20);
        wait_bursts(5);
        check_value(saw_full, "pix_ready never dropped");
        for (int b = 0; b < 5; b++) check_burst(b);
    endtask

    task automatic back_to_back_test();
        @(negedge clk_phy);
        lane_count = 3'd4;
        clear_monitor();
        send_words(12);
        wait_bursts(3);
        for (int b = 0; b < 3; b++) begin
            if (b > 0) begin
                check_value(gap_before[b] >= dsi_tx_pkg::HS_EXIT_CYCLES,
                            $sformatf("burst %0d gap %0d", b, gap_before[b]));
            end
            check_burst(b);
        end
    endtask

    initial begin
        errors     = 0;
        seed       = 32'he184;
        arst_n     = 1'b0;
        pix_data   = '0;
        pix_valid  = 1'b0;
        lane_count = 3'd4;
        nb         = 0;
        lp11_run   = 0;
        in_burst   = 1'b0;
        seen_sync  = 1'b0;
        leak       = 1'b0;
        saw_full   = 1'b0;
        repeat (16) @(negedge clk_phy);
        arst_n = 1'b1;
        @(negedge clk_phy);
        check_value(lp_p == '1 && lp_n == '1, "lp lines not at LP-11 after reset");
        check_value(hs_en == '0 && hs_valid == '0, "hs active after reset");
        check_value(pix_ready, "pix_ready low after reset");
        one_line_test(4);
        one_line_test(1);
        one_line_test(2);
        backpressure_test();
        back_to_back_test();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
